/* design/crc_macros.svh */
// Register map, CR field positions and reset values of the AHB CRC calculator.
// Include in any block that decodes registers or needs their reset values.

`ifndef CRC_MACROS_SVH
`define CRC_MACROS_SVH

// Register indexes, taken from HADDR[4:2]
`define CRC_DR_ADDR    3'h0
`define CRC_IDR_ADDR   3'h1
`define CRC_CR_ADDR    3'h2
`define CRC_INIT_ADDR  3'h4
`define CRC_POL_ADDR   3'h5

// CR bit positions
`define CRC_CR_RESET_BIT  0
`define CRC_CR_CFG_LSB    3
`define CRC_CR_CFG_MSB    7

// Reset values
`define CRC_INIT_RESET  32'hFFFF_FFFF
`define CRC_POL_RESET   32'h04C1_1DB7
`define CRC_CR_RESET    5'h00

`endif

/* design/crc_pkg.sv */
// Types shared by the CRC calculator blocks.
// Import into any block that carries the configuration, the data word or the byte stream.

package crc_pkg;

	////////////////////////////////////////////////////////////
	// Control register fields, in CR[7:3] order
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		// Reverse the full 32-bit result
		logic       rev_out;
		// 00 none, 01 per byte, 10 per halfword, 11 per word
		logic [1:0] rev_in;
		// 00 32 bit, 01 16 bit, 10 8 bit, 11 7 bit
		logic [1:0] poly_size;
	} crc_cfg_t;

	////////////////////////////////////////////////////////////
	// DR write word, whole or as byte lanes
	////////////////////////////////////////////////////////////

	typedef union packed
	{
		logic [31:0]     word;
		logic [3:0][7:0] lanes;
	} crc_word_u;

	// One input byte on its way from the buffer to the engine
	typedef struct packed
	{
		logic       valid;
		logic [7:0] data;
	} crc_byte_t;

endpackage

/* design/host_interface.sv */
// AHB-Lite front end of the CRC calculator.
// Registers the address phase, decodes the register map, drives write enables,
// muxes read data and inserts wait states while the datapath is busy.

`timescale 1ns/1ps

`include "crc_macros.svh"

module host_interface
(
	input  logic                   HCLK,
	input  logic                   HRESETn,
	input  logic                   HSElx,
	input  logic [31:0]            HADDR,
	input  logic [1:0]             HTRANS,
	input  logic [2:0]             HSIZE,
	input  logic                   HWRITE,
	input  logic                   HREADY,
	input  logic [31:0]            HWDATA,
	input  logic [31:0]            crc_out,
	input  logic [31:0]            crc_init_out,
	input  logic [31:0]            crc_poly_out,
	input  logic [7:0]             crc_idr_out,
	input  logic                   buffer_full,
	input  logic                   reset_pending,
	input  logic                   read_wait,
	output logic [31:0]            HRDATA,
	output logic                   HREADYOUT,
	output logic                   HRESP,
	output crc_pkg::crc_word_u     bus_wr,
	output logic [1:0]             bus_size,
	output crc_pkg::crc_cfg_t      cfg,
	output logic                   buffer_write_en,
	output logic                   crc_init_en,
	output logic                   crc_idr_en,
	output logic                   crc_poly_en,
	output logic                   reset_chain
);

	import crc_pkg::*;

	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Address phase copies
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	crc_cfg_t   cfg_q;
	logic       sample_bus;
	logic       write_acc;
	logic       read_acc;
	logic       dr_wr;
	logic       dr_rd;
	logic       init_wr;
	logic       stall;

	////////////////////////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////////////////////////

	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			hselx_pp <= 1'b0;
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Only NONSEQ transfers touch a register
	assign write_acc = hselx_pp && hwrite_pp && (htrans_pp == HTRANS_NONSEQ);
	assign read_acc  = hselx_pp && !hwrite_pp && (htrans_pp == HTRANS_NONSEQ);

	assign dr_wr   = write_acc && (haddr_pp == `CRC_DR_ADDR);
	assign dr_rd   = read_acc && (haddr_pp == `CRC_DR_ADDR);
	assign init_wr = write_acc && (haddr_pp == `CRC_INIT_ADDR);

	////////////////////////////////////////////////////////////
	// Wait states
	////////////////////////////////////////////////////////////

	// Each busy flag holds only the access that depends on it
	assign stall = (dr_wr && buffer_full) || (dr_rd && read_wait) ||
	               (init_wr && reset_pending);

	assign HREADYOUT = !stall;
	// Errors are never signalled
	assign HRESP     = 1'b0;

	// Enables fire once, in the completing data phase cycle
	assign buffer_write_en = dr_wr && !stall;
	assign crc_init_en     = init_wr && !stall;
	assign crc_idr_en      = write_acc && (haddr_pp == `CRC_IDR_ADDR);
	assign crc_poly_en     = write_acc && (haddr_pp == `CRC_POL_ADDR);
	assign reset_chain     = write_acc && (haddr_pp == `CRC_CR_ADDR) &&
	                         bus_wr.word[`CRC_CR_RESET_BIT];

	// Write data is taken straight from the data phase
	assign bus_wr.word = HWDATA;
	assign bus_size    = hsize_pp;

	////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= `CRC_CR_RESET;
		else if (write_acc && (haddr_pp == `CRC_CR_ADDR))
			cfg_q <= bus_wr.lanes[0][`CRC_CR_CFG_MSB:`CRC_CR_CFG_LSB];
	end

	assign cfg = cfg_q;

	// Read mux, CR bit 0 reads back as zero
	always_comb
	begin
		case (haddr_pp)
			`CRC_DR_ADDR:   HRDATA = crc_out;
			`CRC_IDR_ADDR:  HRDATA = {24'h0, crc_idr_out};
			`CRC_CR_ADDR:   HRDATA = {24'h0, cfg_q, 3'b000};
			`CRC_INIT_ADDR: HRDATA = crc_init_out;
			`CRC_POL_ADDR:  HRDATA = crc_poly_out;
			default:        HRDATA = 32'h0;
		endcase
	end

	// Address phase that is not a selected NONSEQ write enables nothing in its data phase
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(sample_bus && !(HSElx && HWRITE && (HTRANS == HTRANS_NONSEQ)))
		|=> !(buffer_write_en || crc_init_en || crc_idr_en || crc_poly_en || reset_chain));

	// DR read held off by read_wait is still pending next cycle
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(dr_rd && read_wait) |=> dr_rd);

endmodule

/* design/crc_buffer.sv */
// Holding register for one DR write.
// Applies input bit reversal and streams 1, 2 or 4 bytes, low lane first.

`timescale 1ns/1ps

module crc_buffer
(
	input  logic                HCLK,
	input  logic                HRESETn,
	input  crc_pkg::crc_word_u  bus_wr,
	input  logic [1:0]          bus_size,
	input  logic                buffer_write_en,
	input  logic [1:0]          rev_in,
	input  logic                reset_chain,
	output crc_pkg::crc_byte_t  byte_out,
	output logic                buffer_full
);

	import crc_pkg::*;

	crc_word_u  data_q;
	crc_word_u  rev_word;
	logic [2:0] count_q;
	logic [2:0] load_count;

	// Bit reversal within a byte, a halfword or the whole word
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			case (rev_in)
				2'b01:   rev_word.word[i] = bus_wr.word[(i & ~7) + 7 - (i & 7)];
				2'b10:   rev_word.word[i] = bus_wr.word[(i & ~15) + 15 - (i & 15)];
				2'b11:   rev_word.word[i] = bus_wr.word[31 - i];
				default: rev_word.word[i] = bus_wr.word[i];
			endcase
		end
	end

	// Byte count from HSIZE
	always_comb
	begin
		case (bus_size)
			2'd0:    load_count = 3'd1;
			2'd1:    load_count = 3'd2;
			default: load_count = 3'd4;
		endcase
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn || reset_chain)
			count_q <= 3'd0;
		else if (buffer_write_en)
			count_q <= load_count;
		else if (count_q != 3'd0)
			count_q <= count_q - 3'd1;
	end

	// Data word shifts down one lane per emitted byte
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			data_q <= rev_word;
		else if (count_q != 3'd0)
			data_q.word <= data_q.word >> 8;
	end

	assign byte_out.data  = data_q.lanes[0];
	assign byte_out.valid = (count_q != 3'd0);
	assign buffer_full    = (count_q != 3'd0);

	// Front end must hold a DR write until the buffer drains
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en |-> !buffer_full);

endmodule

/* design/crc_regs.sv */
// Software registers of the CRC calculator: INIT, POL and IDR.
// Also raises the one-cycle restart that reloads the engine from INIT.

`timescale 1ns/1ps

`include "crc_macros.svh"

module crc_regs
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] bus_wr,
	input  logic        crc_init_en,
	input  logic        crc_poly_en,
	input  logic        crc_idr_en,
	input  logic        reset_chain,
	output logic [31:0] crc_init_out,
	output logic [31:0] crc_poly_out,
	output logic [7:0]  crc_idr_out,
	output logic        restart,
	output logic        reset_pending
);

	logic pending_q;

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_out <= `CRC_INIT_RESET;
			crc_poly_out <= `CRC_POL_RESET;
			// Free byte, upper bits are dropped
			crc_idr_out  <= 8'h00;
		end
		else
		begin
			if (crc_init_en)
				crc_init_out <= bus_wr;
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
			if (crc_idr_en)
				crc_idr_out <= bus_wr[7:0];
		end
	end

	// Pending for one cycle after CR restart or INIT write
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			pending_q <= 1'b0;
		else
			pending_q <= reset_chain || crc_init_en;
	end

	assign restart       = pending_q;
	assign reset_pending = pending_q;

	// INIT is never overwritten while its reload is outstanding
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		crc_init_en |-> !reset_pending);

endmodule

/* design/crc_engine.sv */
// Byte-serial CRC datapath for 7, 8, 16 and 32 bit polynomials.
// State is kept left-aligned in 32 bits and one byte is folded in per clock.

`timescale 1ns/1ps

module crc_engine
(
	input  logic               HCLK,
	input  logic               HRESETn,
	input  crc_pkg::crc_byte_t byte_in,
	input  crc_pkg::crc_cfg_t  cfg,
	input  logic [31:0]        crc_init_out,
	input  logic [31:0]        crc_poly_out,
	input  logic               restart,
	input  logic               buffer_full,
	output logic [31:0]        crc_out,
	output logic               read_wait
);

	logic [31:0] state_q;
	logic [31:0] next_state;
	logic [31:0] mask_al;
	logic [31:0] poly_al;
	logic [31:0] aligned;
	logic [31:0] reversed;
	logic [4:0]  shift;

	// Left shift that puts the polynomial MSB at bit 31
	always_comb
	begin
		case (cfg.poly_size)
			2'b00:   shift = 5'd0;
			2'b01:   shift = 5'd16;
			2'b10:   shift = 5'd24;
			default: shift = 5'd25;
		endcase
	end

	assign mask_al = 32'hFFFF_FFFF << shift;
	assign poly_al = crc_poly_out << shift;

	// Eight division steps, data byte enters at the top
	always_comb
	begin
		next_state = state_q ^ {byte_in.data, 24'h0};
		for (int i = 0; i < 8; i++)
		begin
			if (next_state[31])
				next_state = (next_state << 1) ^ poly_al;
			else
				next_state = next_state << 1;
		end
		next_state = next_state & mask_al;
	end

	// Restart wins over a byte in the same cycle
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			state_q <= '1;
		else if (restart)
			state_q <= (crc_init_out << shift) & mask_al;
		else if (byte_in.valid)
			state_q <= next_state;
	end

	////////////////////////////////////////////////////////////
	// Result
	////////////////////////////////////////////////////////////

	assign aligned = state_q >> shift;

	always_comb
	begin
		for (int i = 0; i < 32; i++)
			reversed[i] = aligned[31 - i];
	end

	assign crc_out = cfg.rev_out ? reversed : aligned;

	// Result not final while bytes or a reload are outstanding
	assign read_wait = buffer_full || byte_in.valid || restart;

endmodule

/* design/crc_ahb_top.sv */
// Top level of the AHB-Lite CRC calculator.
// Connects the bus front end, data buffer, register block and CRC engine.

`timescale 1ns/1ps

module crc_ahb_top
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSElx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	import crc_pkg::*;

	crc_word_u   bus_wr;
	crc_cfg_t    cfg;
	crc_byte_t   byte_stream;
	logic [1:0]  bus_size;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        buffer_write_en;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        reset_chain;
	logic        buffer_full;
	logic        reset_pending;
	logic        read_wait;
	logic        restart;

	////////////////////////////////////////////////////////////
	// Bus front end
	////////////////////////////////////////////////////////////

	host_interface host_interface_inst
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HREADY          (HREADY),
		.HWDATA          (HWDATA),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.crc_idr_out     (crc_idr_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.cfg             (cfg),
		.buffer_write_en (buffer_write_en),
		.crc_init_en     (crc_init_en),
		.crc_idr_en      (crc_idr_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	// Input bytes, reversal taken from CR
	crc_buffer crc_buffer_inst
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.bus_wr          (bus_wr),
		.bus_size        (bus_size),
		.buffer_write_en (buffer_write_en),
		.rev_in          (cfg.rev_in),
		.reset_chain     (reset_chain),
		.byte_out        (byte_stream),
		.buffer_full     (buffer_full)
	);

	crc_regs crc_regs_inst
	(
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.bus_wr        (bus_wr.word),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.crc_idr_en    (crc_idr_en),
		.reset_chain   (reset_chain),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.crc_idr_out   (crc_idr_out),
		.restart       (restart),
		.reset_pending (reset_pending)
	);

	crc_engine crc_engine_inst
	(
		.HCLK         (HCLK),
		.HRESETn      (HRESETn),
		.byte_in      (byte_stream),
		.cfg          (cfg),
		.crc_init_out (crc_init_out),
		.crc_poly_out (crc_poly_out),
		.restart      (restart),
		.buffer_full  (buffer_full),
		.crc_out      (crc_out),
		.read_wait    (read_wait)
	);

endmodule

/* tb/tb_crc_ahb.sv */
// Table-driven AHB-Lite testbench for the CRC calculator.
// Applies one register transfer per table entry, models the CRC bit by bit
// and checks every read against literal or modelled values.

`timescale 1ns/1ps

`include "crc_macros.svh"

module tb_crc_ahb;

	localparam logic [1:0] TRANS_IDLE   = 2'b00;
	localparam logic [1:0] TRANS_NONSEQ = 2'b10;
	localparam int         RESET_CYCLES = 10;

	// Read expectation source, or random write data
	localparam logic [1:0] EXP_FIXED = 2'd0;
	localparam logic [1:0] EXP_MODEL = 2'd1;
	localparam logic [1:0] DATA_RAND = 2'd2;

	typedef struct packed
	{
		logic        wr;
		logic [2:0]  idx;
		logic [2:0]  size;
		logic [1:0]  mode;
		logic [31:0] data;
		logic [31:0] expected;
	} txn_t;

	logic        HCLK;
	logic        HRESETn;
	logic        HSElx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic        HREADY;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	txn_t        txns[$];
	int          errors = 0;
	int          cycles = 0;
	int          limit  = 0;

	// Reference model state, CR kept in register layout
	logic [31:0] m_crc;
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [7:0]  m_cr;

	crc_ahb_top crc_ahb_top_inst (.*);

	initial
	begin
		HCLK = 1'b0;
		forever #5 HCLK = ~HCLK;
	end

	////////////////////////////////////////////////////////////
	// Reference CRC model
	////////////////////////////////////////////////////////////

	function automatic int width_of(input logic [1:0] poly_size);
		case (poly_size)
			2'b00:   return 32;
			2'b01:   return 16;
			2'b10:   return 8;
			default: return 7;
		endcase
	endfunction

	function automatic logic [31:0] width_mask(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'h1 << w) - 32'h1);
	endfunction

	// Mirror bits inside each group of g bits
	function automatic logic [31:0] reverse_groups(input logic [31:0] d, input int g);
		logic [31:0] r;
		for (int base = 0; base < 32; base += g)
			for (int k = 0; k < g; k++)
				r[base + k] = d[base + g - 1 - k];
		return r;
	endfunction

	// Plain LFSR form, message bit enters at the top, MSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b,
		input int w, input logic [31:0] poly);
		logic fb;
		for (int i = 7; i >= 0; i--)
		begin
			fb  = crc[w - 1] ^ b[i];
			crc = (crc << 1) & width_mask(w);
			if (fb)
				crc = crc ^ (poly & width_mask(w));
		end
		return crc;
	endfunction

	task automatic feed_model(input logic [31:0] data, input logic [2:0] size);
		logic [31:0] word;
		int          nbytes;
		int          group;
		// 00 keeps the order, then 8, 16 or 32 bit groups
		group  = (m_cr[6:5] == 2'b00) ? 1 : (4 << m_cr[6:5]);
		word   = reverse_groups(data, group);
		nbytes = (size == 3'd0) ? 1 : ((size == 3'd1) ? 2 : 4);
		for (int i = 0; i < nbytes; i++)
			m_crc = crc_byte(m_crc, word[8 * i +: 8], width_of(m_cr[4:3]), m_poly);
	endtask

	task automatic apply_write(input logic [2:0] idx, input logic [2:0] size,
		input logic [31:0] data);
		case (idx)
			`CRC_DR_ADDR:
				feed_model(data, size);
			`CRC_CR_ADDR:
			begin
				m_cr = data[7:0] & 8'hF8;
				if (data[0])
					m_crc = m_init & width_mask(width_of(m_cr[4:3]));
			end
			`CRC_INIT_ADDR:
			begin
				m_init = data;
				m_crc  = data & width_mask(width_of(m_cr[4:3]));
			end
			`CRC_POL_ADDR:
				m_poly = data;
			default:
				;
		endcase
	endtask

	function automatic logic [31:0] expected_read(input logic [2:0] idx);
		logic [31:0] r;
		r = m_crc & width_mask(width_of(m_cr[4:3]));
		if (m_cr[7])
			r = reverse_groups(r, 32);
		case (idx)
			`CRC_DR_ADDR:   return r;
			`CRC_CR_ADDR:   return {24'h0, m_cr};
			`CRC_INIT_ADDR: return m_init;
			`CRC_POL_ADDR:  return m_poly;
			default:        return 32'h0;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Transaction table
	////////////////////////////////////////////////////////////

	task automatic write_entry(input logic [2:0] idx, input logic [2:0] size,
		input logic [31:0] data);
		txn_t t;
		t = '{1'b1, idx, size, EXP_FIXED, data, 32'h0};
		txns.push_back(t);
	endtask

	task automatic rand_entry(input logic [2:0] size);
		txn_t t;
		t = '{1'b1, `CRC_DR_ADDR, size, DATA_RAND, 32'h0, 32'h0};
		txns.push_back(t);
	endtask

	task automatic read_entry(input logic [2:0] idx, input logic [1:0] mode,
		input logic [31:0] expected);
		txn_t t;
		t = '{1'b0, idx, 3'd2, mode, 32'h0, expected};
		txns.push_back(t);
	endtask

	// ASCII 123456789, lanes in message order
	task automatic digits_entries();
		write_entry(`CRC_DR_ADDR, 3'd2, 32'h3433_3231);
		write_entry(`CRC_DR_ADDR, 3'd2, 32'h3837_3635);
		write_entry(`CRC_DR_ADDR, 3'd0, 32'h0000_0039);
	endtask

	task automatic build_table();
		// Reset values
		read_entry(`CRC_INIT_ADDR, EXP_FIXED, 32'hFFFF_FFFF);
		read_entry(`CRC_POL_ADDR, EXP_FIXED, 32'h04C1_1DB7);
		read_entry(`CRC_CR_ADDR, EXP_FIXED, 32'h0);
		read_entry(`CRC_IDR_ADDR, EXP_FIXED, 32'h0);
		// IDR low byte, INIT readback and reload
		write_entry(`CRC_IDR_ADDR, 3'd2, 32'hA5C3_1E77);
		read_entry(`CRC_IDR_ADDR, EXP_FIXED, 32'h0000_0077);
		write_entry(`CRC_INIT_ADDR, 3'd2, 32'h1234_5678);
		read_entry(`CRC_INIT_ADDR, EXP_FIXED, 32'h1234_5678);
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'h1234_5678);
		// CRC-32/MPEG-2 check value, then random words
		write_entry(`CRC_INIT_ADDR, 3'd2, 32'hFFFF_FFFF);
		digits_entries();
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'h0376_E6E7);
		rand_entry(3'd2);
		rand_entry(3'd2);
		read_entry(`CRC_DR_ADDR, EXP_MODEL, 32'h0);
		// 16 bit CCITT check value
		write_entry(`CRC_POL_ADDR, 3'd2, 32'h0000_1021);
		read_entry(`CRC_POL_ADDR, EXP_FIXED, 32'h0000_1021);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_0009);
		digits_entries();
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'h0000_29B1);
		// 8 bit and 7 bit sizes with byte and halfword writes
		write_entry(`CRC_POL_ADDR, 3'd2, 32'h0000_0007);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_0011);
		rand_entry(3'd0);
		rand_entry(3'd1);
		read_entry(`CRC_DR_ADDR, EXP_MODEL, 32'h0);
		write_entry(`CRC_POL_ADDR, 3'd2, 32'h0000_0009);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_0019);
		rand_entry(3'd1);
		rand_entry(3'd2);
		read_entry(`CRC_DR_ADDR, EXP_MODEL, 32'h0);
		// Byte reversal in and out gives the JAMCRC check value
		write_entry(`CRC_POL_ADDR, 3'd2, 32'h04C1_1DB7);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_00A1);
		read_entry(`CRC_CR_ADDR, EXP_FIXED, 32'h0000_00A0);
		digits_entries();
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'h340B_C6D9);
		// Halfword and word input reversal
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_00C1);
		read_entry(`CRC_CR_ADDR, EXP_FIXED, 32'h0000_00C0);
		rand_entry(3'd2);
		read_entry(`CRC_DR_ADDR, EXP_MODEL, 32'h0);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_0061);
		read_entry(`CRC_CR_ADDR, EXP_FIXED, 32'h0000_0060);
		rand_entry(3'd1);
		read_entry(`CRC_DR_ADDR, EXP_MODEL, 32'h0);
		// Restart by INIT write, then by CR while bytes are still queued
		write_entry(`CRC_INIT_ADDR, 3'd2, 32'h89AB_CDEF);
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'h89AB_CDEF);
		rand_entry(3'd2);
		write_entry(`CRC_CR_ADDR, 3'd2, 32'h0000_0091);
		read_entry(`CRC_DR_ADDR, EXP_FIXED, 32'hF700_0000);
	endtask

	////////////////////////////////////////////////////////////
	// Bus driver
	////////////////////////////////////////////////////////////

	task automatic bus_transfer(input txn_t t, input logic [31:0] wdata,
		output logic [31:0] rdata, output int waits);
		waits = 0;
		@(posedge HCLK);
		HSElx  <= 1'b1;
		HADDR  <= {27'h0, t.idx, 2'b00};
		HTRANS <= TRANS_NONSEQ;
		HSIZE  <= t.size;
		HWRITE <= t.wr;
		@(posedge HCLK);
		HSElx  <= 1'b0;
		HTRANS <= TRANS_IDLE;
		HWDATA <= wdata;
		// Data phase completes at the first edge seen with HREADYOUT high
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			waits++;
			@(negedge HCLK);
		end
		rdata = HRDATA;
	endtask

	// HRESP must stay OKAY
	always @(negedge HCLK)
	begin
		if (HRESETn)
		begin
			assert (HRESP === 1'b0)
			else
			begin
				errors++;
				$display("** Error: HRESP = %h, expected %h", HRESP, 1'b0);
			end
		end
	end

	always @(posedge HCLK)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("Timeout: run did not finish within %0d cycles, %0d errors", limit, errors);
			$display("Verification failed");
			$finish;
		end
	end

	initial
	begin
		txn_t        t;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] expected;
		int          waits;
		void'($urandom(41460));
		HRESETn = 1'b0;
		HSElx   = 1'b0;
		HADDR   = 32'h0;
		HTRANS  = TRANS_IDLE;
		HSIZE   = 3'd2;
		HWRITE  = 1'b0;
		HREADY  = 1'b1;
		HWDATA  = 32'h0;
		m_crc   = 32'hFFFF_FFFF;
		m_init  = 32'hFFFF_FFFF;
		m_poly  = 32'h04C1_1DB7;
		m_cr    = 8'h00;
		build_table();
		limit = 20 * txns.size() + RESET_CYCLES;
		repeat (RESET_CYCLES) @(posedge HCLK);
		HRESETn <= 1'b1;
		foreach (txns[i])
		begin
			t     = txns[i];
			wdata = (t.mode == DATA_RAND) ? $urandom() : t.data;
			bus_transfer(t, wdata, rdata, waits);
			// Only DR accesses and INIT writes may be held
			if (!(t.idx == `CRC_DR_ADDR || (t.wr && t.idx == `CRC_INIT_ADDR)))
			begin
				assert (waits == 0)
				else
				begin
					errors++;
					$display("** Error: HREADYOUT wait states entry %0d = %h, expected %h",
						i, waits, 0);
				end
			end
			if (t.wr)
				apply_write(t.idx, t.size, wdata);
			else
			begin
				expected = (t.mode == EXP_MODEL) ? expected_read(t.idx) : t.expected;
				assert (rdata === expected)
				else
				begin
					errors++;
					$display("** Error: HRDATA entry %0d reg %h = %h, expected %h",
						i, t.idx, rdata, expected);
				end
			end
		end
		@(posedge HCLK);
		$display("Run complete: %0d transfers, %0d errors", txns.size(), errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* flist.f */
+incdir+design
design/crc_pkg.sv
design/host_interface.sv
design/crc_buffer.sv
design/crc_regs.sv
design/crc_engine.sv
design/crc_ahb_top.sv
tb/tb_crc_ahb.sv

/* Makefile */
# Verilator flow for the AHB CRC calculator

TOP := tb_crc_ahb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
